// File: Makefile
FILELIST := uart_dma_tx.f

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module uart_dma_tx_tb -f $(FILELIST)
	verilator --lint-only --top-module uart_dma_tx uart_dma_pkg.sv baud_tick_gen.sv \
		tx_dma_fetch.sv byte_fifo.sv tx_serializer.sv uart_dma_tx.sv

obj_dir/sim: $(shell cat $(FILELIST))
	verilator --binary --timing --top-module uart_dma_tx_tb -f $(FILELIST) -o sim

sim: obj_dir/sim
	./obj_dir/sim

clean:
	rm -rf obj_dir

// File: baud_tick_gen.sv
`timescale 1ns/100ps

module baud_tick_gen import uart_dma_pkg::*; (
    input  logic clk,
    input  logic ptr_rst,
    output logic tick
);

    logic [BAUD_CW-1:0] cnt;
    logic               wrap;

    assign wrap = (cnt == BAUD_CW'(BAUD_DIV - 1));

    // Free-running divider, restarted by reset so tick phase is known.
    always_ff @(posedge clk) begin
        if (ptr_rst) begin
            cnt <= '0;
        end else if (wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // One clock wide pulse each time the counter wraps.
    assign tick = wrap;

endmodule

// File: byte_fifo.sv
`timescale 1ns/100ps

module byte_fifo import uart_dma_pkg::*; (
    input  logic       clk,
    input  logic       ptr_rst,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       full,
    output logic       empty
);

    logic [7:0]       mem [FIFO_DEPTH];
    logic [FIFO_AW:0] wr_ptr;
    logic [FIFO_AW:0] rd_ptr;
    logic             do_wr;
    logic             do_rd;

    // The extra pointer bit tells a full buffer from an empty one.
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
                   (wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

    assign do_wr = wr_en & ~full;
    assign do_rd = rd_en & ~empty;

    always_ff @(posedge clk) begin
        if (ptr_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= wr_data;
        end
    end

    // Head entry, visible without a read strobe.
    assign rd_data = mem[rd_ptr[FIFO_AW-1:0]];

endmodule

// File: tx_dma_fetch.sv
`timescale 1ns/100ps

module tx_dma_fetch import uart_dma_pkg::*; (
    input  logic              clk,
    input  logic              ptr_rst,
    input  logic              en,
    input  logic              load,
    input  dma_window_t       window,
    input  logic              fifo_full,
    input  logic              fifo_empty,
    input  logic              ser_busy,
    input  logic [7:0]        mem_data,
    input  logic              mem_ready,
    output logic              mem_req,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              wr_en,
    output logic [7:0]        wr_data,
    output logic              done
);

    fetch_state_t      state;
    logic [ADDR_W-1:0] ptr;
    logic              at_end;
    logic              start_fetch;

    assign at_end = (ptr == window.buf_end);

    // The transfer is over once the pointer has reached the end of the window
    // and every fetched byte has left the line.
    assign done = en & at_end & fifo_empty & ~ser_busy;

    // Only one byte is ever in flight, so a free slot seen here is still
    // free when the byte is pushed.
    assign start_fetch = en & ~done & ~fifo_full & ~at_end;

    always_ff @(posedge clk) begin
        if (ptr_rst) begin
            state <= FETCH_IDLE;
            ptr   <= '0;
        end else if (load) begin
            state <= FETCH_IDLE;
            ptr   <= window.buf_start;
        end else if (!en) begin
            // Pointer is kept so the transfer resumes where it stopped.
            state <= FETCH_IDLE;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (start_fetch) begin
                        state <= FETCH_WAIT;
                    end
                end
                FETCH_WAIT: begin
                    if (mem_ready) begin
                        state <= FETCH_PUSH;
                    end
                end
                FETCH_PUSH: begin
                    state <= FETCH_IDLE;
                    ptr   <= ptr + 1'b1;
                end
                default: begin
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // Memory data is only valid in the mem_ready cycle.
    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT && mem_ready) begin
            wr_data <= mem_data;
        end
    end

    assign mem_req  = (state == FETCH_WAIT);
    assign mem_addr = ptr;
    assign wr_en    = (state == FETCH_PUSH);

endmodule

// File: tx_serializer.sv
`timescale 1ns/100ps

module tx_serializer import uart_dma_pkg::*; (
    input  logic       clk,
    input  logic       ptr_rst,
    input  logic       tick,
    input  logic [7:0] rd_data,
    input  logic       empty,
    output logic       rd_en,
    output logic       busy,
    output logic       tx
);

    ser_state_t state;
    logic [7:0] shift_q;
    logic [2:0] bit_cnt;

    // A byte is accepted only on a tick while idle.
    assign rd_en = (state == SER_IDLE) & tick & ~empty;
    assign busy  = (state != SER_IDLE);

    always_ff @(posedge clk) begin
        if (ptr_rst) begin
            state   <= SER_IDLE;
            bit_cnt <= '0;
            tx      <= 1'b1;
        end else if (tick) begin
            case (state)
                SER_IDLE: begin
                    if (!empty) begin
                        state <= SER_START;
                        tx    <= 1'b0;
                    end
                end
                SER_START: begin
                    state   <= SER_DATA;
                    bit_cnt <= '0;
                    tx      <= shift_q[0];
                end
                SER_DATA: begin
                    if (bit_cnt == 3'd7) begin
                        state <= SER_STOP;
                        tx    <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                        tx      <= shift_q[0];
                    end
                end
                SER_STOP: begin
                    // Line stays high, stop bit ends on this tick.
                    state <= SER_IDLE;
                end
                default: begin
                    state <= SER_IDLE;
                    tx    <= 1'b1;
                end
            endcase
        end
    end

    // Data leaves LSB first, so the register shifts right as bits go out.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            shift_q <= rd_data;
        end else if (tick && (state == SER_START || state == SER_DATA)) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule

// File: uart_dma_pkg.sv
package uart_dma_pkg;

    // Memory address width used by the fetch port.
    localparam int ADDR_W = 32;

    // Transmit FIFO geometry. FIFO_AW must equal log2 of FIFO_DEPTH.
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_AW = 3;

    // Clock cycles per serial bit.
    localparam int BAUD_DIV = 4;

    // Width of the baud counter.
    localparam int BAUD_CW = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

    // Byte window in memory, from buf_start up to but not including buf_end.
    typedef struct packed {
        logic [ADDR_W-1:0] buf_start;
        logic [ADDR_W-1:0] buf_end;
    } dma_window_t;

    // Fetch stage phases.
    // FETCH_WAIT holds the memory request until the memory answers.
    // FETCH_PUSH writes the captured byte into the FIFO.
    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_WAIT = 2'd1,
        FETCH_PUSH = 2'd2
    } fetch_state_t;

    // Serializer frame phases, one bit time each except SER_DATA,
    // which spans the eight data bits.
    typedef enum logic [1:0] {
        SER_IDLE  = 2'd0,
        SER_START = 2'd1,
        SER_DATA  = 2'd2,
        SER_STOP  = 2'd3
    } ser_state_t;

endpackage

// File: uart_dma_tx.f
uart_dma_pkg.sv
baud_tick_gen.sv
tx_dma_fetch.sv
byte_fifo.sv
tx_serializer.sv
uart_dma_tx.sv
uart_dma_tx_tb.sv

// File: uart_dma_tx.sv
`timescale 1ns/100ps

module uart_dma_tx import uart_dma_pkg::*; (
    input  logic              clk,
    input  logic              ptr_rst,
    input  logic              en,
    input  logic              load,
    input  dma_window_t       window,
    input  logic [7:0]        mem_data,
    input  logic              mem_ready,
    output logic              mem_req,
    output logic [ADDR_W-1:0] mem_addr,
    output logic              done,
    output logic              tx
);

    logic       tick;
    logic       wr_en;
    logic [7:0] wr_data;
    logic       rd_en;
    logic [7:0] rd_data;
    logic       fifo_full;
    logic       fifo_empty;
    logic       ser_busy;

    baud_tick_gen i_tick (
        .clk     (clk),
        .ptr_rst (ptr_rst),
        .tick    (tick)
    );

    tx_dma_fetch i_fetch (
        .clk        (clk),
        .ptr_rst    (ptr_rst),
        .en         (en),
        .load       (load),
        .window     (window),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .ser_busy   (ser_busy),
        .mem_data   (mem_data),
        .mem_ready  (mem_ready),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .done       (done)
    );

    byte_fifo i_fifo (
        .clk     (clk),
        .ptr_rst (ptr_rst),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .full    (fifo_full),
        .empty   (fifo_empty)
    );

    tx_serializer i_ser (
        .clk     (clk),
        .ptr_rst (ptr_rst),
        .tick    (tick),
        .rd_data (rd_data),
        .empty   (fifo_empty),
        .rd_en   (rd_en),
        .busy    (ser_busy),
        .tx      (tx)
    );

endmodule

// File: uart_dma_tx_tb.sv
`timescale 1ns/100ps

module uart_dma_tx_tb import uart_dma_pkg::*; ();

    localparam int MAX_TESTS = 64;
    localparam int FRAME_CYCLES = 10 * BAUD_DIV;

    logic              clk;
    logic              ptr_rst;
    logic              en;
    logic              load;
    dma_window_t       window;
    logic [7:0]        mem_data;
    logic              mem_ready;
    logic              mem_req;
    logic [ADDR_W-1:0] mem_addr;
    logic              done;
    logic              tx;

    logic [31:0] t_start [MAX_TESTS];
    logic [31:0] t_end   [MAX_TESTS];
    logic [31:0] t_delay [MAX_TESTS];
    logic [31:0] t_count [MAX_TESTS];
    logic [31:0] t_xor   [MAX_TESTS];
    logic [31:0] t_abort [MAX_TESTS];
    int          num_tests;
    int          limit_cycles;
    logic        limit_ready;

    integer            seed;
    logic [31:0]       delay_code;
    logic [ADDR_W-1:0] exp_base;
    int                rx_count;
    logic [7:0]        rx_xor;
    logic              prev_en;

    uart_dma_tx i_dut (
        .clk       (clk),
        .ptr_rst   (ptr_rst),
        .en        (en),
        .load      (load),
        .window    (window),
        .mem_data  (mem_data),
        .mem_ready (mem_ready),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .done      (done),
        .tx        (tx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s: got %h, expected %h", $time, msg, actual,
                     expected);
            $display("Test failed");
            $fatal(1, "value check");
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s at %0t ns", msg, $time);
        $display("Test failed");
        $fatal(1, "run aborted");
    endtask

    // Programs a new window with load, then raises en on the next edge.
    task automatic program_window(input logic [31:0] lo, input logic [31:0] hi);
        @(posedge clk);
        window <= {lo, hi};
        load   <= 1'b1;
        en     <= 1'b0;
        @(posedge clk);
        load   <= 1'b0;
        en     <= 1'b1;
    endtask

    task automatic read_tests();
        int    fd;
        int    n;
        string line;
        fd = $fopen("uart_dma_tx_tests.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the test data file");
        end
        num_tests = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h", t_start[num_tests],
                            t_end[num_tests], t_delay[num_tests], t_count[num_tests],
                            t_xor[num_tests], t_abort[num_tests]);
                if (n != 6) begin
                    abort_run("A line of the test data file is malformed");
                end
                num_tests++;
            end
        end
        $fclose(fd);
    endtask

    // Memory model. The byte at address a is a[7:0] ^ 8'h5A.
    initial begin
        logic [ADDR_W-1:0] addr;
        int                d;
        forever begin
            @(negedge clk);
            if (mem_req === 1'b1) begin
                addr = mem_addr;
                if (delay_code == 0) begin
                    d = $random(seed) & 7;
                end else begin
                    d = delay_code;
                end
                @(posedge clk);
                repeat (d) @(posedge clk);
                mem_ready <= 1'b1;
                mem_data  <= addr[7:0] ^ 8'h5A;
                @(posedge clk);
                mem_ready <= 1'b0;
                @(negedge clk);
            end
        end
    end

    // Line decoder, sampling each bit near its middle.
    initial begin
        logic [7:0]        data;
        logic [ADDR_W-1:0] addr;
        forever begin
            @(negedge tx);
            if (ptr_rst !== 1'b1) begin
                repeat (BAUD_DIV / 2) @(negedge clk);
                check_value(32'(tx), 32'd0, "start bit");
                for (int i = 0; i < 8; i++) begin
                    repeat (BAUD_DIV) @(negedge clk);
                    data[i] = tx;
                end
                repeat (BAUD_DIV) @(negedge clk);
                check_value(32'(tx), 32'd1, "stop bit");
                addr = exp_base + rx_count;
                check_value(32'(data), 32'(addr[7:0] ^ 8'h5A), "received byte");
                rx_count++;
                rx_xor ^= data;
            end
        end
    end

    // Bus monitor for the memory request and done.
    always @(negedge clk) begin
        if (ptr_rst === 1'b0) begin
            if (en === 1'b0 && done === 1'b1) begin
                abort_run("done was high while en was low");
            end
            if (mem_req === 1'b1) begin
                if (en !== 1'b1 && prev_en !== 1'b1) begin
                    abort_run("mem_req was high while en was low");
                end
                if (done === 1'b1) begin
                    abort_run("mem_req was high after done");
                end
                if (mem_addr < window.buf_start || mem_addr >= window.buf_end) begin
                    abort_run("mem_addr left the window during a request");
                end
            end
        end
        prev_en <= en;
    end

    initial begin
        wait (limit_ready === 1'b1);
        repeat (limit_cycles) @(posedge clk);
        abort_run("Watchdog expired before all tests finished");
    end

    initial begin
        seed        = 32'he658_194c;
        ptr_rst     = 1'b1;
        en          = 1'b0;
        load        = 1'b0;
        window      = '0;
        mem_data    = '0;
        mem_ready   = 1'b0;
        delay_code  = 1;
        exp_base    = '0;
        rx_count    = 0;
        rx_xor      = '0;
        prev_en     = 1'b0;
        limit_ready = 1'b0;

        read_tests();
        limit_cycles = 100;
        for (int i = 0; i < num_tests; i++) begin
            limit_cycles += (t_count[i] + t_abort[i] + 12) * (FRAME_CYCLES + 12);
        end
        limit_ready = 1'b1;

        repeat (3) @(posedge clk);
        ptr_rst <= 1'b0;
        @(negedge clk);
        check_value(32'(tx), 32'd1, "tx after reset");
        check_value(32'(mem_req), 32'd0, "mem_req after reset");
        check_value(mem_addr, '0, "pointer after reset");

        for (int i = 0; i < num_tests; i++) begin
            delay_code = t_delay[i];
            if (t_abort[i] != 0) begin
                // Partial transfer from another window, then a restart.
                exp_base = t_start[i] + 32'h40;
                rx_count = 0;
                rx_xor   = '0;
                program_window(t_start[i] + 32'h40, t_start[i] + 32'h60);
                do @(negedge clk); while (rx_count < t_abort[i]);
                @(posedge clk);
                en <= 1'b0;
                repeat ((FIFO_DEPTH + 2) * FRAME_CYCLES) @(negedge clk);
                check_value(32'(tx), 32'd1, "tx idle after stopped transfer");
            end
            exp_base = t_start[i];
            rx_count = 0;
            rx_xor   = '0;
            program_window(t_start[i], t_end[i]);
            do @(negedge clk); while (done !== 1'b1);
            check_value(rx_count, t_count[i], "byte count at done");
            check_value(32'(rx_xor), t_xor[i], "XOR of received bytes");
            check_value(32'(tx), 32'd1, "tx at done");
            @(posedge clk);
            en <= 1'b0;
            repeat (FRAME_CYCLES) @(negedge clk);
            check_value(rx_count, t_count[i], "byte count after done");
            check_value(32'(tx), 32'd1, "tx between transfers");
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: uart_dma_tx_tests.txt
# Columns, all hex: start end ready_delay count xor abort_bytes
# ready_delay 0 means random 0..7 cycles; abort_bytes > 0 runs a stopped transfer first.
100 104 1 4 00 0
200 208 0 8 00 0
300 303 14 3 59 0
400 400 2 0 00 0
510 520 1 10 00 0
600 605 3 5 5E 3
7F0 7F6 19 6 01 0
1FE 202 0 4 00 0
A0 A1 7 1 FA 0
800 802 0 2 01 1
